// ==== src/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

	parameter int DATA_WIDTH = 32;
	parameter int INST_WIDTH = 32;
	parameter int REG_ADDR_WIDTH = 5;

	parameter logic [DATA_WIDTH-1:0] RESET_PC = 32'h8000_0000;

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// follows funct3 where one exists
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_NONE = 3'b010,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branch_op_e;

endpackage

`default_nettype wire

// ==== src/rv_imem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_imem import rv_core_pkg::*; #(
	parameter int IMEM_ADDR_WIDTH = 8
) (
	input  wire logic                       clk,
	input  wire logic                       wen,
	input  wire logic [IMEM_ADDR_WIDTH-1:0] waddr,
	input  wire logic [INST_WIDTH-1:0]      wdata,
	input  wire logic [IMEM_ADDR_WIDTH-1:0] raddr,
	output      logic [INST_WIDTH-1:0]      rdata
);

	localparam int DEPTH = 2 ** IMEM_ADDR_WIDTH;

	logic [INST_WIDTH-1:0] mem [DEPTH];

	// program load port
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// read every cycle, output acts as the IF/ID boundary
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
	input  wire logic                      clk,
	input  wire logic [REG_ADDR_WIDTH-1:0] rs1_addr,
	input  wire logic [REG_ADDR_WIDTH-1:0] rs2_addr,
	output      logic [DATA_WIDTH-1:0]     rs1_data,
	output      logic [DATA_WIDTH-1:0]     rs2_data,
	input  wire logic                      rd_en,
	input  wire logic [REG_ADDR_WIDTH-1:0] rd_addr,
	input  wire logic [DATA_WIDTH-1:0]     rd_data
);

	// x0 has no storage
	logic [DATA_WIDTH-1:0] regs [1:31];

	logic wr_live;

	assign wr_live = rd_en && (rd_addr != '0);

	always_ff @(posedge clk) begin
		if (wr_live) begin
			regs[rd_addr] <= rd_data;
		end
	end

	// write-through so decode sees the retiring result
	always_comb begin
		if (rs1_addr == '0) rs1_data = '0;
		else if (wr_live && (rd_addr == rs1_addr)) rs1_data = rd_data;
		else rs1_data = regs[rs1_addr];
	end

	always_comb begin
		if (rs2_addr == '0) rs2_data = '0;
		else if (wr_live && (rd_addr == rs2_addr)) rs2_data = rd_data;
		else rs2_data = regs[rs2_addr];
	end

	// register written last cycle reads back its data unless bypassed again
	write_read_back: assert property (@(posedge clk) wr_live |=>
		(rs1_addr != $past(rd_addr)) || (wr_live && (rd_addr == rs1_addr))
		|| (rs1_data == $past(rd_data)))
		else $error("register read back differs from the data written");

endmodule

`default_nettype wire

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_core_pkg::*; (
	input  wire logic [INST_WIDTH-1:0]     inst,
	output      logic [REG_ADDR_WIDTH-1:0] rs1_addr,
	output      logic [REG_ADDR_WIDTH-1:0] rs2_addr,
	output      logic [REG_ADDR_WIDTH-1:0] rd_addr,
	output      logic                      rd_en,
	output      alu_op_e                   alu_op,
	output      logic                      alu_a_pc,
	output      logic                      alu_b_imm,
	output      logic [DATA_WIDTH-1:0]     imm,
	output      branch_op_e                branch_op,
	output      logic                      is_jal,
	output      logic                      is_jalr,
	output      logic                      is_ebreak
);

	localparam logic [INST_WIDTH-1:0] EBREAK_INST = 32'h0010_0073;

	opcode_e               opcode;
	logic [2:0]            funct3;
	logic                  rd_write;
	logic [DATA_WIDTH-1:0] imm_i;
	logic [DATA_WIDTH-1:0] imm_b;
	logic [DATA_WIDTH-1:0] imm_u;
	logic [DATA_WIDTH-1:0] imm_j;

	// alt is inst[30]; sub only exists for register-register ops
	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt,
			input logic allow_sub);
		case (f3)
			3'b000:  return (alt && allow_sub) ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode   = opcode_e'(inst[6:0]);
	assign funct3   = inst[14:12];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign rd_addr  = inst[11:7];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// writes to x0 never show as a register write
	assign rd_en = rd_write && (rd_addr != '0);

	always_comb begin
		rd_write  = 1'b0;
		alu_op    = ALU_ADD;
		alu_a_pc  = 1'b0;
		alu_b_imm = 1'b0;
		imm       = '0;
		branch_op = BR_NONE;
		is_jal    = 1'b0;
		is_jalr   = 1'b0;
		is_ebreak = 1'b0;
		case (opcode)
			OPC_OP: begin
				rd_write = 1'b1;
				alu_op   = alu_from_funct3(funct3, inst[30], 1'b1);
			end
			OPC_OP_IMM: begin
				rd_write  = 1'b1;
				alu_op    = alu_from_funct3(funct3, inst[30], 1'b0);
				alu_b_imm = 1'b1;
				imm       = imm_i;
			end
			OPC_LUI: begin
				rd_write  = 1'b1;
				alu_op    = ALU_PASS_B;
				alu_b_imm = 1'b1;
				imm       = imm_u;
			end
			OPC_AUIPC: begin
				rd_write  = 1'b1;
				alu_a_pc  = 1'b1;
				alu_b_imm = 1'b1;
				imm       = imm_u;
			end
			// jump target comes out of the ALU add
			OPC_JAL: begin
				rd_write  = 1'b1;
				alu_a_pc  = 1'b1;
				alu_b_imm = 1'b1;
				imm       = imm_j;
				is_jal    = 1'b1;
			end
			OPC_JALR: begin
				rd_write  = 1'b1;
				alu_b_imm = 1'b1;
				imm       = imm_i;
				is_jalr   = 1'b1;
			end
			OPC_BRANCH: begin
				imm = imm_b;
				case (funct3)
					3'b000:  branch_op = BR_BEQ;
					3'b001:  branch_op = BR_BNE;
					3'b100:  branch_op = BR_BLT;
					3'b101:  branch_op = BR_BGE;
					3'b110:  branch_op = BR_BLTU;
					3'b111:  branch_op = BR_BGEU;
					default: branch_op = BR_NONE;
				endcase
			end
			OPC_SYSTEM: begin
				is_ebreak = (inst == EBREAK_INST);
			end
			default: begin
				// unsupported, retires as a no-op
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
	input  wire alu_op_e               alu_op,
	input  wire logic [DATA_WIDTH-1:0] a,
	input  wire logic [DATA_WIDTH-1:0] b,
	output      logic [DATA_WIDTH-1:0] result
);

	logic [4:0]            shamt;
	logic                  lt_signed;
	logic                  lt_unsigned;
	logic [DATA_WIDTH-1:0] sum;
	logic [DATA_WIDTH-1:0] diff;

	assign shamt       = b[4:0];
	assign sum         = a + b;
	assign diff        = a - b;
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = sum;
			ALU_SUB:    result = diff;
			ALU_SLL:    result = a << shamt;
			ALU_SLT:    result = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
			ALU_SLTU:   result = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
			ALU_XOR:    result = a ^ b;
			ALU_SRL:    result = a >> shamt;
			// arithmetic shift keeps the sign
			ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/rv_branch_cmp.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_branch_cmp import rv_core_pkg::*; (
	input  wire branch_op_e            branch_op,
	input  wire logic [DATA_WIDTH-1:0] rs1,
	input  wire logic [DATA_WIDTH-1:0] rs2,
	output      logic                  taken
);

	logic eq;
	logic lt;
	logic ltu;

	// own comparators, independent of the ALU
	assign eq  = (rs1 == rs2);
	assign lt  = $signed(rs1) < $signed(rs2);
	assign ltu = rs1 < rs2;

	always_comb begin
		case (branch_op)
			BR_BEQ:  taken = eq;
			BR_BNE:  taken = !eq;
			BR_BLT:  taken = lt;
			BR_BGE:  taken = !lt;
			BR_BLTU: taken = ltu;
			BR_BGEU: taken = !ltu;
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/rv_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_writeback import rv_core_pkg::*; (
	input  wire logic                      valid,
	input  wire logic [DATA_WIDTH-1:0]     pc,
	input  wire logic [DATA_WIDTH-1:0]     alu_result,
	input  wire logic                      taken,
	input  wire logic [DATA_WIDTH-1:0]     imm,
	input  wire logic                      is_jal,
	input  wire logic                      is_jalr,
	input  wire logic                      rd_en,
	input  wire logic [REG_ADDR_WIDTH-1:0] rd_addr,
	output      logic                      redirect,
	output      logic [DATA_WIDTH-1:0]     redirect_pc,
	output      logic                      rf_we,
	output      logic [REG_ADDR_WIDTH-1:0] rf_addr,
	output      logic [DATA_WIDTH-1:0]     rf_data
);

	logic                  is_jump;
	logic [DATA_WIDTH-1:0] link_pc;
	logic [DATA_WIDTH-1:0] jump_pc;

	assign is_jump = is_jal || is_jalr;
	assign link_pc = pc + DATA_WIDTH'(4);

	// jalr target has bit 0 forced low
	assign jump_pc = {alu_result[DATA_WIDTH-1:1], alu_result[0] & !is_jalr};

	assign rf_we   = valid && rd_en;
	assign rf_addr = rd_addr;
	assign rf_data = is_jump ? link_pc : alu_result;

	assign redirect    = valid && (taken || is_jump);
	assign redirect_pc = is_jump ? jump_pc : (pc + imm);

endmodule

`default_nettype wire

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
	parameter int IMEM_ADDR_WIDTH = 8
) (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       imem_wen,
	input  wire logic [IMEM_ADDR_WIDTH-1:0] imem_addr,
	input  wire logic [INST_WIDTH-1:0]      imem_wdata,
	output      logic                       retire_valid,
	output      logic [DATA_WIDTH-1:0]      retire_pc,
	output      logic                       retire_rd_we,
	output      logic [REG_ADDR_WIDTH-1:0]  retire_rd_addr,
	output      logic [DATA_WIDTH-1:0]      retire_rd_data,
	output      logic                       halted
);

	logic [DATA_WIDTH-1:0] pc;

	// decode stage
	logic [DATA_WIDTH-1:0]     id_pc;
	logic                      id_valid;
	logic [INST_WIDTH-1:0]     id_inst;
	logic [REG_ADDR_WIDTH-1:0] id_rs1_addr;
	logic [REG_ADDR_WIDTH-1:0] id_rs2_addr;
	logic [REG_ADDR_WIDTH-1:0] id_rd_addr;
	logic                      id_rd_en;
	alu_op_e                   id_alu_op;
	logic                      id_alu_a_pc;
	logic                      id_alu_b_imm;
	logic [DATA_WIDTH-1:0]     id_imm;
	branch_op_e                id_branch_op;
	logic                      id_is_jal;
	logic                      id_is_jalr;
	logic                      id_is_ebreak;
	logic [DATA_WIDTH-1:0]     id_rs1_data;
	logic [DATA_WIDTH-1:0]     id_rs2_data;

	// execute stage
	logic                      ex_valid;
	logic [DATA_WIDTH-1:0]     ex_pc;
	logic [DATA_WIDTH-1:0]     ex_rs1;
	logic [DATA_WIDTH-1:0]     ex_rs2;
	logic [DATA_WIDTH-1:0]     ex_imm;
	alu_op_e                   ex_alu_op;
	logic                      ex_alu_a_pc;
	logic                      ex_alu_b_imm;
	branch_op_e                ex_branch_op;
	logic                      ex_is_jal;
	logic                      ex_is_jalr;
	logic                      ex_is_ebreak;
	logic                      ex_rd_en;
	logic [REG_ADDR_WIDTH-1:0] ex_rd_addr;
	logic [DATA_WIDTH-1:0]     alu_a;
	logic [DATA_WIDTH-1:0]     alu_b;
	logic [DATA_WIDTH-1:0]     alu_result;
	logic                      br_taken;

	logic                      redirect;
	logic [DATA_WIDTH-1:0]     redirect_pc;
	logic                      rf_we;
	logic [REG_ADDR_WIDTH-1:0] rf_addr;
	logic [DATA_WIDTH-1:0]     rf_data;
	logic                      ebreak_retire;
	logic                      squash;

	assign ebreak_retire = ex_valid && ex_is_ebreak;
	// kills the two younger instructions
	assign squash = redirect || ebreak_retire || halted;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc       <= RESET_PC;
			id_valid <= 1'b0;
			ex_valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			if (redirect) pc <= redirect_pc;
			else if (!halted && !ebreak_retire) pc <= pc + DATA_WIDTH'(4);
			id_valid <= !squash;
			ex_valid <= id_valid && !squash;
			if (ebreak_retire) halted <= 1'b1;
		end
	end

	// payload, qualified by the valid bits
	always_ff @(posedge clk) begin
		id_pc        <= pc;
		ex_pc        <= id_pc;
		ex_rs1       <= id_rs1_data;
		ex_rs2       <= id_rs2_data;
		ex_imm       <= id_imm;
		ex_alu_op    <= id_alu_op;
		ex_alu_a_pc  <= id_alu_a_pc;
		ex_alu_b_imm <= id_alu_b_imm;
		ex_branch_op <= id_branch_op;
		ex_is_jal    <= id_is_jal;
		ex_is_jalr   <= id_is_jalr;
		ex_is_ebreak <= id_is_ebreak;
		ex_rd_en     <= id_rd_en;
		ex_rd_addr   <= id_rd_addr;
	end

	rv_imem #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) u_imem (
		.clk(clk), .wen(imem_wen), .waddr(imem_addr), .wdata(imem_wdata),
		.raddr(pc[IMEM_ADDR_WIDTH+1:2]), .rdata(id_inst)
	);

	rv_decode u_decode (
		.inst(id_inst), .rs1_addr(id_rs1_addr), .rs2_addr(id_rs2_addr),
		.rd_addr(id_rd_addr), .rd_en(id_rd_en), .alu_op(id_alu_op),
		.alu_a_pc(id_alu_a_pc), .alu_b_imm(id_alu_b_imm), .imm(id_imm),
		.branch_op(id_branch_op), .is_jal(id_is_jal), .is_jalr(id_is_jalr),
		.is_ebreak(id_is_ebreak)
	);

	rv_regfile u_regfile (
		.clk(clk), .rs1_addr(id_rs1_addr), .rs2_addr(id_rs2_addr),
		.rs1_data(id_rs1_data), .rs2_data(id_rs2_data),
		.rd_en(rf_we), .rd_addr(rf_addr), .rd_data(rf_data)
	);

	assign alu_a = ex_alu_a_pc ? ex_pc : ex_rs1;
	assign alu_b = ex_alu_b_imm ? ex_imm : ex_rs2;

	rv_alu u_alu (.alu_op(ex_alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

	rv_branch_cmp u_branch_cmp (
		.branch_op(ex_branch_op), .rs1(ex_rs1), .rs2(ex_rs2), .taken(br_taken)
	);

	rv_writeback u_writeback (
		.valid(ex_valid), .pc(ex_pc), .alu_result(alu_result), .taken(br_taken),
		.imm(ex_imm), .is_jal(ex_is_jal), .is_jalr(ex_is_jalr), .rd_en(ex_rd_en),
		.rd_addr(ex_rd_addr), .redirect(redirect), .redirect_pc(redirect_pc),
		.rf_we(rf_we), .rf_addr(rf_addr), .rf_data(rf_data)
	);

	assign retire_valid   = ex_valid;
	assign retire_pc      = ex_pc;
	assign retire_rd_we   = rf_we;
	assign retire_rd_addr = rf_addr;
	assign retire_rd_data = rf_data;

	no_retire_when_halted: assert property (
		@(posedge clk) disable iff (!rst_n) halted |-> !retire_valid)
		else $error("retire after halt");

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD_NS = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = !clk;

endmodule

`default_nettype wire

// ==== verification/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural state, x0 is never written
logic [DATA_WIDTH-1:0] ref_pc;
logic [DATA_WIDTH-1:0] ref_regs [32];

// executes one instruction at ref_pc and returns what its retire must show
function automatic void ref_step(input logic [31:0] inst, output logic [31:0] exp_pc,
		output logic exp_we, output logic [4:0] exp_rd, output logic [31:0] exp_data,
		output logic exp_halt);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] rs2v;
	logic [31:0] imm_i;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [31:0] next_pc;
	logic        cond;
	imm_i = {{20{inst[31]}}, inst[31:20]};
	imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	a = ref_regs[inst[19:15]];
	rs2v = ref_regs[inst[24:20]];
	b = (inst[6:0] == 7'h33) ? rs2v : imm_i;
	next_pc = ref_pc + 32'd4;
	exp_pc = ref_pc;
	exp_we = 1'b0;
	exp_rd = inst[11:7];
	exp_data = '0;
	exp_halt = 1'b0;
	cond = 1'b0;
	case (inst[6:0])
		7'h33, 7'h13: begin
			exp_we = 1'b1;
			case (inst[14:12])
				// sub only for the register form
				3'd0: exp_data = (inst[5] && inst[30]) ? a - b : a + b;
				3'd1: exp_data = a << b[4:0];
				3'd2: exp_data = {31'b0, $signed(a) < $signed(b)};
				3'd3: exp_data = {31'b0, a < b};
				3'd4: exp_data = a ^ b;
				3'd5: begin
					if (inst[30]) exp_data = $signed(a) >>> b[4:0];
					else exp_data = a >> b[4:0];
				end
				3'd6: exp_data = a | b;
				default: exp_data = a & b;
			endcase
		end
		7'h37: begin
			exp_we = 1'b1;
			exp_data = {inst[31:12], 12'b0};
		end
		7'h17: begin
			exp_we = 1'b1;
			exp_data = ref_pc + {inst[31:12], 12'b0};
		end
		7'h6f: begin
			exp_we = 1'b1;
			exp_data = ref_pc + 32'd4;
			next_pc = ref_pc + imm_j;
		end
		7'h67: begin
			exp_we = 1'b1;
			exp_data = ref_pc + 32'd4;
			next_pc = (a + imm_i) & ~32'd1;
		end
		7'h63: begin
			case (inst[14:12])
				3'd0: cond = (a == rs2v);
				3'd1: cond = (a != rs2v);
				3'd4: cond = ($signed(a) < $signed(rs2v));
				3'd5: cond = ($signed(a) >= $signed(rs2v));
				3'd6: cond = (a < rs2v);
				3'd7: cond = (a >= rs2v);
				default: cond = 1'b0;
			endcase
			if (cond) next_pc = ref_pc + imm_b;
		end
		7'h73: exp_halt = (inst == EBREAK_INST);
		default: exp_we = 1'b0;
	endcase
	if (exp_rd == 5'd0) exp_we = 1'b0;
	if (exp_we) ref_regs[exp_rd] = exp_data;
	ref_pc = next_pc;
endfunction

`endif

// ==== verification/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core import rv_core_pkg::*; ();

	localparam int IMEM_AW = 8;
	localparam logic [INST_WIDTH-1:0] EBREAK_INST = 32'h0010_0073;
	localparam int WAIT_LIMIT = 50;
	localparam int QUIET_CYCLES = 20;
	localparam int MAX_RETIRES = 4096;

	// branch kind and operand registers, first pair taken, second not
	localparam int BR_F3 [6] = '{0, 1, 4, 5, 6, 7};
	localparam int TK_A [6] = '{3, 3, 1, 4, 3, 2};
	localparam int TK_B [6] = '{3, 4, 3, 1, 1, 3};
	localparam int NT_A [6] = '{3, 2, 4, 1, 2, 3};
	localparam int NT_B [6] = '{4, 2, 1, 2, 3, 4};

	logic                      clk;
	logic                      rst_n;
	logic                      imem_wen;
	logic [IMEM_AW-1:0]        imem_addr;
	logic [INST_WIDTH-1:0]     imem_wdata;
	logic                      retire_valid;
	logic [DATA_WIDTH-1:0]     retire_pc;
	logic                      retire_rd_we;
	logic [REG_ADDR_WIDTH-1:0] retire_rd_addr;
	logic [DATA_WIDTH-1:0]     retire_rd_data;
	logic                      halted;

	logic [INST_WIDTH-1:0] prog [$];
	string                 test_name;
	int                    test_errors;
	int                    tests_run;
	int                    tests_failed;

	`include "tb_ref_model.svh"

	clk_gen #(.PERIOD_NS(10)) u_clk_gen (.clk(clk));

	rv_core_top #(.IMEM_ADDR_WIDTH(IMEM_AW)) uut (
		.clk(clk), .rst_n(rst_n), .imem_wen(imem_wen), .imem_addr(imem_addr),
		.imem_wdata(imem_wdata), .retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd_we(retire_rd_we), .retire_rd_addr(retire_rd_addr),
		.retire_rd_data(retire_rd_data), .halted(halted)
	);

	function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
			input int rs1, input int rs2);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input int f3, input int rd,
			input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int upper);
		return {20'(upper), 5'(rd), opc};
	endfunction

	function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
			input int off);
		logic [12:0] o;
		o = 13'(off);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input int rd, input int off);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		int idx;
		idx = int'((addr - RESET_PC) >> 2);
		if (idx < prog.size()) return prog[idx];
		return 32'h0;
	endfunction

	task automatic compare_value(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERR %s %s expected %08h actual %08h", test_name, field, expected, actual);
			test_errors++;
		end
	endtask

	// edge values in x1..x4
	task automatic start_program();
		prog.delete();
		prog.push_back(enc_u(7'h37, 1, 'h80000));
		prog.push_back(enc_i(7'h13, 0, 2, 0, -1));
		prog.push_back(enc_i(7'h13, 0, 3, 0, 5));
		prog.push_back(enc_i(7'h13, 0, 4, 1, -1));
	endtask

	task automatic run_program(input string name);
		logic [DATA_WIDTH-1:0]     exp_pc;
		logic [DATA_WIDTH-1:0]     exp_data;
		logic [REG_ADDR_WIDTH-1:0] exp_rd;
		logic                      exp_we;
		logic                      exp_halt;
		int                        waited;
		int                        retires;
		int                        exp_gap;
		test_name = name;
		test_errors = 0;
		prog.push_back(EBREAK_INST);
		// program goes in while the core sits in reset
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		foreach (prog[i]) begin
			imem_wen = 1'b1;
			imem_addr = IMEM_AW'(i);
			imem_wdata = prog[i];
			@(posedge clk);
			#1;
		end
		imem_wen = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		ref_pc = RESET_PC;
		retires = 0;
		exp_halt = 1'b0;
		// first retire two cycles after reset release
		exp_gap = 2;
		while (!exp_halt && retires < MAX_RETIRES) begin
			waited = 0;
			@(negedge clk);
			while (!retire_valid && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (!retire_valid) begin
				$display("%s: no instruction retired within %0d cycles", test_name, WAIT_LIMIT);
				test_errors++;
				break;
			end
			retires++;
			compare_value("retire_gap", 32'(exp_gap), 32'(waited));
			ref_step(fetch_word(ref_pc), exp_pc, exp_we, exp_rd, exp_data, exp_halt);
			compare_value("retire_pc", exp_pc, retire_pc);
			compare_value("rd_we", 32'(exp_we), 32'(retire_rd_we));
			if (exp_we) begin
				compare_value("rd_addr", 32'(exp_rd), 32'(retire_rd_addr));
				compare_value("rd_data", exp_data, retire_rd_data);
			end
			// a redirect leaves two squashed slots
			exp_gap = (ref_pc != exp_pc + 32'd4) ? 2 : 0;
		end
		if (exp_halt) begin
			waited = 0;
			while (!halted && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (!halted) begin
				$display("%s: halted did not rise after the ebreak retired", test_name);
				test_errors++;
			end else begin
				// core must stay quiet once halted
				repeat (QUIET_CYCLES) begin
					@(negedge clk);
					if (retire_valid) begin
						$display("%s: retire pulse seen while halted", test_name);
						test_errors++;
					end
				end
			end
		end else if (retires >= MAX_RETIRES) begin
			$display("%s: no ebreak after %0d retires", test_name, retires);
			test_errors++;
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("test %-8s ok, %0d retires", test_name, retires);
		end else begin
			tests_failed++;
			$display("test %-8s failed with %0d errors", test_name, test_errors);
		end
	endtask

	initial begin
		int f3;
		int f7;
		int rd;
		int r;
		int imm;
		void'($urandom(32'hff2d));
		rst_n = 1'b0;
		imem_wen = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		tests_run = 0;
		tests_failed = 0;
		foreach (ref_regs[i]) ref_regs[i] = '0;

		start_program();
		for (int k = 0; k < 10; k++) begin
			f3 = (k < 8) ? k : ((k == 8) ? 0 : 5);
			f7 = (k < 8) ? 0 : 'h20;
			prog.push_back(enc_r(f7, f3, 5 + k, 1, 2));
			prog.push_back(enc_r(f7, f3, 15 + k, 4, 1));
			prog.push_back(enc_r(f7, f3, 25 + k % 4, 3, 2));
			prog.push_back(enc_r(f7, f3, 29 + k % 3, 2, 3));
		end
		run_program("alu_rr");

		start_program();
		for (int k = 0; k < 8; k++) begin
			if (k == 1 || k == 5) begin
				prog.push_back(enc_i(7'h13, k, 5 + k, 1, 7));
				prog.push_back(enc_i(7'h13, k, 13 + k, 2, 31));
			end else begin
				prog.push_back(enc_i(7'h13, k, 5 + k, 1, -3));
				prog.push_back(enc_i(7'h13, k, 13 + k, 4, 2047));
				prog.push_back(enc_i(7'h13, k, 21 + k, 3, -2048));
			end
		end
		// srai form, then upper-immediate ops
		prog.push_back(enc_i(7'h13, 5, 29, 1, 'h407));
		prog.push_back(enc_u(7'h37, 30, 'habcde));
		prog.push_back(enc_u(7'h17, 31, 'h12345));
		prog.push_back(enc_u(7'h17, 28, 'hfffff));
		run_program("alu_imm");

		start_program();
		prog.push_back(enc_i(7'h13, 0, 5, 0, 1));
		for (int k = 0; k < 6; k++) begin
			prog.push_back(enc_r(0, 0, 5, 5, 5));
		end
		prog.push_back(enc_r('h20, 0, 6, 5, 3));
		prog.push_back(enc_r(0, 4, 7, 6, 5));
		prog.push_back(enc_r(0, 1, 8, 7, 3));
		prog.push_back(enc_i(7'h13, 7, 9, 8, 255));
		prog.push_back(enc_r(0, 3, 10, 9, 8));
		prog.push_back(enc_r(0, 0, 11, 10, 10));
		run_program("bypass");

		start_program();
		for (int k = 0; k < 6; k++) begin
			for (int t = 0; t < 2; t++) begin
				prog.push_back(enc_b(BR_F3[k], (t == 1) ? NT_A[k] : TK_A[k],
					(t == 1) ? NT_B[k] : TK_B[k], 12));
				prog.push_back(enc_i(7'h13, 0, 10, 0, 1 + k));
				prog.push_back(enc_i(7'h13, 0, 10, 0, 100 + k));
				prog.push_back(enc_i(7'h13, 0, 11, 0, 200 + k));
			end
		end
		// short backward loop, three passes
		prog.push_back(enc_i(7'h13, 0, 12, 0, 3));
		prog.push_back(enc_i(7'h13, 0, 12, 12, -1));
		prog.push_back(enc_b(1, 12, 0, -4));
		run_program("branch");

		start_program();
		prog.push_back(enc_j(5, 12));
		prog.push_back(enc_i(7'h13, 0, 12, 0, 1));
		prog.push_back(enc_i(7'h13, 0, 12, 0, 2));
		prog.push_back(enc_u(7'h17, 6, 0));
		// odd offsets, bit 0 of the target drops
		prog.push_back(enc_i(7'h67, 0, 7, 6, 13));
		prog.push_back(enc_i(7'h13, 0, 12, 0, 3));
		prog.push_back(enc_i(7'h13, 0, 13, 0, 4));
		prog.push_back(enc_j(0, 8));
		prog.push_back(enc_i(7'h13, 0, 12, 0, 5));
		prog.push_back(enc_i(7'h13, 0, 13, 13, 1));
		prog.push_back(enc_i(7'h67, 0, 8, 5, 45));
		prog.push_back(enc_i(7'h13, 0, 12, 0, 6));
		prog.push_back(enc_i(7'h13, 0, 14, 8, 0));
		run_program("jump");

		start_program();
		for (int k = 1; k < 32; k++) begin
			prog.push_back(enc_u(7'h37, k, $urandom));
			prog.push_back(enc_i(7'h13, 0, k, k, $urandom));
		end
		for (int k = 0; k < 80; k++) begin
			rd = $urandom_range(0, 31);
			f3 = $urandom_range(0, 7);
			r = $urandom_range(0, 9);
			if (r < 5) begin
				f7 = ((f3 == 0 || f3 == 5) && $urandom_range(0, 1) == 1) ? 'h20 : 0;
				prog.push_back(enc_r(f7, f3, rd, $urandom_range(0, 31), $urandom_range(0, 31)));
			end else if (r < 9) begin
				imm = $urandom;
				// shift immediates keep only shamt and the arithmetic bit
				if (f3 == 1) imm = imm & 'h1f;
				else if (f3 == 5) imm = imm & 'h41f;
				prog.push_back(enc_i(7'h13, f3, rd, $urandom_range(0, 31), imm));
			end else begin
				prog.push_back(enc_u(($urandom_range(0, 1) == 1) ? 7'h37 : 7'h17, rd, $urandom));
			end
		end
		run_program("random");

		$display("tests run %0d, failed %0d", tests_run, tests_failed);
		if (tests_failed == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
src/rv_core_pkg.sv
src/rv_imem.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_alu.sv
src/rv_branch_cmp.sv
src/rv_writeback.sv
src/rv_core_top.sv
verification/clk_gen.sv
verification/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_core -f list.f -o sim_core || exit 1
./obj_dir/sim_core > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
